/* conv_pkg.sv */
`default_nettype none

package conv_pkg;

  // layer operation, taken from bit 7 of the configuration beat
  typedef enum logic {
    op_linear = 1'b0,
    op_lrelu  = 1'b1
  } opcode_t;

  // controller states
  // st_config waits for the configuration beat,
  // st_accum pairs pixel and weight beats,
  // st_drain is a one-cycle gap after the final tap of a layer
  typedef enum logic [1:0] {
    st_config = 2'd0,
    st_accum  = 2'd1,
    st_drain  = 2'd2
  } ctrl_state_t;

  // configuration beat layout in the low byte of the weights word
  //   [3:0]  taps - 1
  //   [6:4]  groups - 1
  //   [7]    opcode

  // taps-minus-one field, up to 16 taps per group
  localparam int CFG_TAPS_LSB = 0;
  localparam int BITS_TAPS = 4;

  // groups-minus-one field, up to 8 groups per layer
  localparam int CFG_GROUPS_LSB = 4;
  localparam int BITS_GROUPS = 3;

  // opcode bit
  localparam int CFG_OP_BIT = 7;

endpackage

`default_nettype wire

/* conv_stream_if.sv */
`timescale 1ns/1ps
`default_nettype none

// result stream from the accumulators to the activation stage
interface conv_stream_if #(
  parameter int UNITS     = 4,
  parameter int ACC_WIDTH = 24
);

  logic                       valid;
  logic                       ready;
  // unit 0 in the low bits
  logic [UNITS*ACC_WIDTH-1:0] data;
  // final group of the layer
  logic                       last;
  conv_pkg::opcode_t          op;

  modport src (
    output valid,
    input  ready,
    output data,
    output last,
    output op
  );

  modport snk (
    input  valid,
    output ready,
    input  data,
    input  last,
    input  op
  );

endinterface

`default_nettype wire

/* layer_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module layer_controller #(
  parameter int WORD_WIDTH = 8
) (
  input  logic                                     aclk,
  input  logic                                     reset,
  input  logic                                     s_pixels_valid,
  output logic                                     s_pixels_ready,
  input  logic                                     s_weights_valid,
  output logic                                     s_weights_ready,
  input  logic [WORD_WIDTH-1:0]                    s_weights_data,
  input  logic                                     can_accept,
  input  logic                                     tap_last,
  input  logic                                     group_last,
  output logic                                     beat_fire,
  output logic                                     end_layer,
  output logic                                     clear,
  output conv_pkg::opcode_t                        cfg_op,
  output logic [conv_pkg::BITS_TAPS-1:0]           cfg_taps_1,
  output logic [conv_pkg::BITS_GROUPS-1:0]         cfg_groups_1
);

  conv_pkg::ctrl_state_t state;
  logic                  cfg_fire;
  logic                  in_accum;

  assign in_accum = (state == conv_pkg::st_accum);

  // configuration beat accepted
  assign cfg_fire = (state == conv_pkg::st_config) && s_weights_valid;

  // both streams hand over together, so each ready waits on the other valid
  assign s_pixels_ready  = in_accum && can_accept && s_weights_valid;
  assign s_weights_ready = (state == conv_pkg::st_config) ||
                           (in_accum && can_accept && s_pixels_valid);

  assign beat_fire = in_accum && can_accept && s_pixels_valid && s_weights_valid;
  assign end_layer = beat_fire && tap_last && group_last;

  // restart the tap and group counts for the new layer
  assign clear = cfg_fire;

  always_ff @(posedge aclk) begin
    if (reset) begin
      state <= conv_pkg::st_config;
    end else begin
      case (state)
        conv_pkg::st_config: begin
          if (cfg_fire) begin
            state <= conv_pkg::st_accum;
          end
        end
        conv_pkg::st_accum: begin
          if (end_layer) begin
            state <= conv_pkg::st_drain;
          end
        end
        default: begin
          state <= conv_pkg::st_config;
        end
      endcase
    end
  end

  // layer fields held for the whole layer
  always_ff @(posedge aclk) begin
    if (cfg_fire) begin
      cfg_op       <= conv_pkg::opcode_t'(s_weights_data[conv_pkg::CFG_OP_BIT]);
      cfg_taps_1   <= s_weights_data[conv_pkg::CFG_TAPS_LSB +: conv_pkg::BITS_TAPS];
      cfg_groups_1 <= s_weights_data[conv_pkg::CFG_GROUPS_LSB +: conv_pkg::BITS_GROUPS];
    end
  end

  // a new layer starts from the first tap of its first group
  a_layer_starts_cleared : assert property (
    @(posedge aclk) disable iff (reset)
    cfg_fire |=> (tap_last == (cfg_taps_1 == '0)) &&
                 (group_last == (cfg_groups_1 == '0))
  );

endmodule

`default_nettype wire

/* tap_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module tap_counter (
  input  logic                             aclk,
  input  logic                             reset,
  input  logic                             clear,
  input  logic                             step,
  input  logic [conv_pkg::BITS_TAPS-1:0]   cfg_taps_1,
  input  logic [conv_pkg::BITS_GROUPS-1:0] cfg_groups_1,
  output logic                             tap_last,
  output logic                             group_last
);

  logic [conv_pkg::BITS_TAPS-1:0]   tap_cnt;
  logic [conv_pkg::BITS_GROUPS-1:0] group_cnt;

  assign tap_last   = (tap_cnt == cfg_taps_1);
  assign group_last = (group_cnt == cfg_groups_1);

  always_ff @(posedge aclk) begin
    if (reset || clear) begin
      tap_cnt   <= '0;
      group_cnt <= '0;
    end else if (step) begin
      if (tap_last) begin
        // wrap taps, move on to the next group
        tap_cnt   <= '0;
        group_cnt <= group_cnt + 1'b1;
      end else begin
        tap_cnt <= tap_cnt + 1'b1;
      end
    end
  end

  // the controller stops stepping after the last tap of the last group
  a_step_within_layer : assert property (
    @(posedge aclk) disable iff (reset)
    step |-> (group_cnt <= cfg_groups_1)
  );

endmodule

`default_nettype wire

/* mac_array.sv */
`timescale 1ns/1ps
`default_nettype none

module mac_array #(
  parameter int UNITS      = 4,
  parameter int WORD_WIDTH = 8,
  parameter int ACC_WIDTH  = 24
) (
  input  logic                        aclk,
  input  logic                        reset,
  input  logic                        beat_fire,
  input  logic                        tap_last,
  input  logic                        end_layer,
  input  conv_pkg::opcode_t           cfg_op,
  input  logic [UNITS*WORD_WIDTH-1:0] pixels,
  input  logic [WORD_WIDTH-1:0]       weight,
  output logic                        can_accept,
  conv_stream_if.src                  res
);

  logic                       first;
  logic                       group_done;
  logic signed [WORD_WIDTH-1:0] weight_s;
  logic [UNITS*ACC_WIDTH-1:0] sum_flat;

  assign weight_s   = weight;
  assign group_done = beat_fire && tap_last;

  // result register is free or draining this cycle
  assign can_accept = !res.valid || res.ready;

  // high until the first tap of a group has been taken
  always_ff @(posedge aclk) begin
    if (reset) begin
      first <= 1'b1;
    end else if (beat_fire) begin
      first <= tap_last;
    end
  end

  for (genvar u = 0; u < UNITS; u++) begin : g_unit
    logic signed [WORD_WIDTH-1:0]   pix;
    logic signed [2*WORD_WIDTH-1:0] prod;
    logic signed [ACC_WIDTH-1:0]    prod_ext;
    logic signed [ACC_WIDTH-1:0]    base;
    logic signed [ACC_WIDTH-1:0]    sum;
    logic signed [ACC_WIDTH-1:0]    acc;

    assign pix      = pixels[u*WORD_WIDTH +: WORD_WIDTH];
    assign prod     = pix * weight_s;
    assign prod_ext = prod;
    // first tap loads the product instead of adding to the old sum
    assign base     = first ? '0 : acc;
    assign sum      = base + prod_ext;

    assign sum_flat[u*ACC_WIDTH +: ACC_WIDTH] = sum;

    always_ff @(posedge aclk) begin
      if (beat_fire) begin
        acc <= sum;
      end
    end
  end

  // one-entry result register
  always_ff @(posedge aclk) begin
    if (reset) begin
      res.valid <= 1'b0;
    end else if (group_done) begin
      res.valid <= 1'b1;
    end else if (res.ready) begin
      res.valid <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (group_done) begin
      res.data <= sum_flat;
      res.last <= end_layer;
      res.op   <= cfg_op;
    end
  end

  a_res_data_held : assert property (
    @(posedge aclk) disable iff (reset)
    (res.valid && !res.ready) |=> $stable(res.data)
  );

endmodule

`default_nettype wire

/* lrelu_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module lrelu_stage #(
  parameter int UNITS       = 4,
  parameter int ACC_WIDTH   = 24,
  parameter int LRELU_SHIFT = 3
) (
  input  logic                       aclk,
  input  logic                       reset,
  conv_stream_if.snk                 res,
  output logic                       m_valid,
  input  logic                       m_ready,
  output logic [UNITS*ACC_WIDTH-1:0] m_data,
  output logic                       m_last
);

  logic                       take;
  logic [UNITS*ACC_WIDTH-1:0] act_flat;

  // output register empty or being read
  assign res.ready = !m_valid || m_ready;
  assign take      = res.valid && res.ready;

  for (genvar u = 0; u < UNITS; u++) begin : g_unit
    logic signed [ACC_WIDTH-1:0] word;
    logic signed [ACC_WIDTH-1:0] act;
    logic                        leak;

    assign word = res.data[u*ACC_WIDTH +: ACC_WIDTH];
    assign leak = (res.op == conv_pkg::op_lrelu) && word[ACC_WIDTH-1];
    // arithmetic shift rounds toward minus infinity
    assign act  = leak ? (word >>> LRELU_SHIFT) : word;

    assign act_flat[u*ACC_WIDTH +: ACC_WIDTH] = act;
  end

  always_ff @(posedge aclk) begin
    if (reset) begin
      m_valid <= 1'b0;
    end else if (res.ready) begin
      m_valid <= res.valid;
    end
  end

  always_ff @(posedge aclk) begin
    if (take) begin
      m_data <= act_flat;
      m_last <= res.last;
    end
  end

  a_m_valid_known : assert property (
    @(posedge aclk) disable iff (reset)
    !$isunknown(m_valid)
  );

endmodule

`default_nettype wire

/* conv_accelerator.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_accelerator #(
  parameter int UNITS       = 4,
  parameter int WORD_WIDTH  = 8,
  parameter int ACC_WIDTH   = 24,
  parameter int LRELU_SHIFT = 3
) (
  input  logic                        aclk,
  input  logic                        reset,

  input  logic                        s_pixels_valid,
  output logic                        s_pixels_ready,
  input  logic [UNITS*WORD_WIDTH-1:0] s_pixels_data,

  input  logic                        s_weights_valid,
  output logic                        s_weights_ready,
  input  logic [WORD_WIDTH-1:0]       s_weights_data,

  output logic                        m_valid,
  input  logic                        m_ready,
  output logic [UNITS*ACC_WIDTH-1:0]  m_data,
  output logic                        m_last
);

  logic                             can_accept;
  logic                             tap_last;
  logic                             group_last;
  logic                             beat_fire;
  logic                             end_layer;
  logic                             clear;
  conv_pkg::opcode_t                cfg_op;
  logic [conv_pkg::BITS_TAPS-1:0]   cfg_taps_1;
  logic [conv_pkg::BITS_GROUPS-1:0] cfg_groups_1;

  conv_stream_if #(
    .UNITS     (UNITS    ),
    .ACC_WIDTH (ACC_WIDTH)
  ) res_if ();

  layer_controller #(
    .WORD_WIDTH (WORD_WIDTH)
  ) u_layer_controller (
    .aclk            (aclk           ),
    .reset           (reset          ),
    .s_pixels_valid  (s_pixels_valid ),
    .s_pixels_ready  (s_pixels_ready ),
    .s_weights_valid (s_weights_valid),
    .s_weights_ready (s_weights_ready),
    .s_weights_data  (s_weights_data ),
    .can_accept      (can_accept     ),
    .tap_last        (tap_last       ),
    .group_last      (group_last     ),
    .beat_fire       (beat_fire      ),
    .end_layer       (end_layer      ),
    .clear           (clear          ),
    .cfg_op          (cfg_op         ),
    .cfg_taps_1      (cfg_taps_1     ),
    .cfg_groups_1    (cfg_groups_1   )
  );

  // each accepted tap beat steps the counter
  tap_counter u_tap_counter (
    .aclk         (aclk        ),
    .reset        (reset       ),
    .clear        (clear       ),
    .step         (beat_fire   ),
    .cfg_taps_1   (cfg_taps_1  ),
    .cfg_groups_1 (cfg_groups_1),
    .tap_last     (tap_last    ),
    .group_last   (group_last  )
  );

  mac_array #(
    .UNITS      (UNITS     ),
    .WORD_WIDTH (WORD_WIDTH),
    .ACC_WIDTH  (ACC_WIDTH )
  ) u_mac_array (
    .aclk       (aclk          ),
    .reset      (reset         ),
    .beat_fire  (beat_fire     ),
    .tap_last   (tap_last      ),
    .end_layer  (end_layer     ),
    .cfg_op     (cfg_op        ),
    .pixels     (s_pixels_data ),
    .weight     (s_weights_data),
    .can_accept (can_accept    ),
    .res        (res_if.src    )
  );

  lrelu_stage #(
    .UNITS       (UNITS      ),
    .ACC_WIDTH   (ACC_WIDTH  ),
    .LRELU_SHIFT (LRELU_SHIFT)
  ) u_lrelu_stage (
    .aclk    (aclk      ),
    .reset   (reset     ),
    .res     (res_if.snk),
    .m_valid (m_valid   ),
    .m_ready (m_ready   ),
    .m_data  (m_data    ),
    .m_last  (m_last    )
  );

endmodule

`default_nettype wire

/* tb_conv_accelerator.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_conv_accelerator;

  localparam int UNITS       = 4;
  localparam int WORD_WIDTH  = 8;
  localparam int ACC_WIDTH   = 24;
  localparam int LRELU_SHIFT = 3;
  localparam int REC_WIDTH   = 4 + UNITS * ACC_WIDTH + 8;
  localparam int MAX_RECORDS = 64;
  localparam int TIMEOUT     = 200;

  logic                        aclk;
  logic                        reset;
  logic                        s_pixels_valid;
  logic                        s_pixels_ready;
  logic [UNITS*WORD_WIDTH-1:0] s_pixels_data;
  logic                        s_weights_valid;
  logic                        s_weights_ready;
  logic [WORD_WIDTH-1:0]       s_weights_data;
  logic                        m_valid;
  logic                        m_ready;
  logic [UNITS*ACC_WIDTH-1:0]  m_data;
  logic                        m_last;

  // kind, field and aux records from conv_trace.txt
  logic [REC_WIDTH-1:0]        trace [0:MAX_RECORDS-1];
  logic [UNITS*WORD_WIDTH-1:0] pixel_q[$];
  logic [WORD_WIDTH-1:0]       weight_q[$];
  logic [UNITS*ACC_WIDTH-1:0]  exp_data_q[$];
  logic                        exp_last_q[$];

  int seed;
  bit gaps;
  int errors;
  int timeouts;

  conv_accelerator #(
    .UNITS       (UNITS      ),
    .WORD_WIDTH  (WORD_WIDTH ),
    .ACC_WIDTH   (ACC_WIDTH  ),
    .LRELU_SHIFT (LRELU_SHIFT)
  ) u_conv_accelerator (
    .aclk            (aclk           ),
    .reset           (reset          ),
    .s_pixels_valid  (s_pixels_valid ),
    .s_pixels_ready  (s_pixels_ready ),
    .s_pixels_data   (s_pixels_data  ),
    .s_weights_valid (s_weights_valid),
    .s_weights_ready (s_weights_ready),
    .s_weights_data  (s_weights_data ),
    .m_valid         (m_valid        ),
    .m_ready         (m_ready        ),
    .m_data          (m_data         ),
    .m_last          (m_last         )
  );

  always #5 aclk = ~aclk;

  task automatic load_trace();
    logic [3:0] kind;
    bit         done;
    pixel_q.delete();
    weight_q.delete();
    exp_data_q.delete();
    exp_last_q.delete();
    done = 1'b0;
    $readmemh("conv_trace.txt", trace);
    for (int i = 0; i < MAX_RECORDS && !done; i++) begin
      kind = trace[i][REC_WIDTH-1 -: 4];
      case (kind)
        4'h1: weight_q.push_back(trace[i][7:0]);
        4'h2: begin
          pixel_q.push_back(trace[i][8 +: UNITS*WORD_WIDTH]);
          weight_q.push_back(trace[i][7:0]);
        end
        4'h3: begin
          exp_data_q.push_back(trace[i][8 +: UNITS*ACC_WIDTH]);
          exp_last_q.push_back(trace[i][0]);
        end
        default: done = 1'b1;
      endcase
    end
    if (exp_data_q.size() == 0) begin
      $display("the trace file conv_trace.txt held no expected outputs");
      errors++;
    end
  endtask

  // config and tap beats on both input streams with valid held until taken
  task automatic send_streams();
    int widx;
    int pidx;
    int idle;
    bit wfire;
    bit pfire;
    widx = 0;
    pidx = 0;
    idle = 0;
    wfire = 1'b1;
    pfire = 1'b1;
    while ((widx < weight_q.size() || pidx < pixel_q.size()) && idle < TIMEOUT) begin
      @(posedge aclk);
      #1;
      if (wfire || !s_weights_valid) begin
        s_weights_valid = (widx < weight_q.size()) && (!gaps || ($random(seed) & 3) != 0);
      end
      if (pfire || !s_pixels_valid) begin
        s_pixels_valid = (pidx < pixel_q.size()) && (!gaps || ($random(seed) & 3) != 0);
      end
      if (widx < weight_q.size()) begin
        s_weights_data = weight_q[widx];
      end
      if (pidx < pixel_q.size()) begin
        s_pixels_data = pixel_q[pidx];
      end
      @(negedge aclk);
      wfire = s_weights_valid && s_weights_ready;
      pfire = s_pixels_valid && s_pixels_ready;
      widx  = widx + wfire;
      pidx  = pidx + pfire;
      idle  = (wfire || pfire) ? 0 : idle + 1;
    end
    @(posedge aclk);
    #1;
    s_weights_valid = 1'b0;
    s_pixels_valid  = 1'b0;
    if (idle >= TIMEOUT) begin
      $display("timeout: input streams stalled with %0d weight and %0d pixel beats sent",
               widx, pidx);
      timeouts++;
    end
  endtask

  task automatic collect_outputs();
    int                         idle;
    bit                         held;
    logic [UNITS*ACC_WIDTH-1:0] held_data;
    logic                       held_last;
    idle = 0;
    held = 1'b0;
    while (exp_data_q.size() > 0 && idle < TIMEOUT) begin
      @(posedge aclk);
      #1;
      m_ready = !gaps || (($random(seed) & 1) != 0);
      @(negedge aclk);
      if (held && (m_valid !== 1'b1 || m_data !== held_data || m_last !== held_last)) begin
        $display("FAILED at %0t: output beat changed while m_ready was low", $time);
        errors++;
      end
      held      = m_valid && !m_ready;
      held_data = m_data;
      held_last = m_last;
      if (m_valid && m_ready) begin
        if (m_data !== exp_data_q[0] || m_last !== exp_last_q[0]) begin
          $display("FAILED at %0t: output %h last %b, expected %h last %b",
                   $time, m_data, m_last, exp_data_q[0], exp_last_q[0]);
          errors++;
        end
        void'(exp_data_q.pop_front());
        void'(exp_last_q.pop_front());
        idle = 0;
      end else begin
        idle++;
      end
    end
    if (idle >= TIMEOUT) begin
      $display("timeout: %0d expected outputs never appeared", exp_data_q.size());
      timeouts++;
    end
  endtask

  // idle ports before any configuration beat
  task automatic check_after_reset();
    repeat (4) begin
      @(negedge aclk);
      if (m_valid !== 1'b0 || s_pixels_ready !== 1'b0 || s_weights_ready !== 1'b1) begin
        $display("FAILED at %0t: after reset m_valid %b s_pixels_ready %b s_weights_ready %b",
                 $time, m_valid, s_pixels_ready, s_weights_ready);
        errors++;
      end
    end
  endtask

  task automatic check_no_extra();
    @(posedge aclk);
    #1;
    m_ready = 1'b1;
    repeat (6) begin
      @(negedge aclk);
      if (m_valid !== 1'b0) begin
        $display("FAILED at %0t: unexpected output beat %h", $time, m_data);
        errors++;
      end
    end
  endtask

  initial begin
    seed            = 32'h6ce9f891;
    errors          = 0;
    timeouts        = 0;
    gaps            = 1'b0;
    aclk            = 1'b0;
    reset           = 1'b1;
    s_pixels_valid  = 1'b0;
    s_pixels_data   = '0;
    s_weights_valid = 1'b0;
    s_weights_data  = '0;
    m_ready         = 1'b0;
    repeat (16) @(posedge aclk);
    #1;
    reset = 1'b0;
    check_after_reset();
    // first pass streams back to back, second with random gaps and back-pressure
    for (int pass = 0; pass < 2; pass++) begin
      gaps = (pass == 1);
      load_trace();
      fork
        send_streams();
        collect_outputs();
      join
      check_no_extra();
    end
    $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* conv_trace.txt */
// kind_field_aux per line. kind 1 config, aux = op[7] groups-1[6:4] taps-1[3:0]
// kind 2 tap, field = pixels (unit 0 low), aux = weight. kind 3 expected, aux = last
// linear layer with 3 taps and 1 group
1_000000000000000000000000_02
2_0000000000000000_0007FD0A_02
2_0000000000000000_01F80405_FD
2_0000000000000000_7F0206FF_04
3_0001F9_00002E_000006_000001_01
// leaky relu layer with 2 taps and 2 groups
1_000000000000000000000000_91
2_0000000000000000_FF03EC0C_05
2_0000000000000000_00F702FC_07
2_0000000000000000_32016480_80
2_0000000000000000_0800CE7F_01
3_FFFFFF_FFFFFA_FFFFF5_000020_00
3_FFFCE1_FFFFF0_FFF9B9_00407F_01
// leaky relu layer with 1 tap and 3 groups
1_000000000000000000000000_A0
2_0000000000000000_FE02FF01_03
2_0000000000000000_08C04000_FE
2_0000000000000000_649C07F9_09
3_FFFFFF_000006_FFFFFF_000003_00
3_FFFFFE_000080_FFFFF0_000000_00
3_000384_FFFF8F_00003F_FFFFF8_01
F_000000000000000000000000_00

/* tb.f */
conv_pkg.sv
conv_stream_if.sv
layer_controller.sv
tap_counter.sv
mac_array.sv
lrelu_stage.sv
conv_accelerator.sv
tb_conv_accelerator.sv
